// ==== dv/exec_tb_cases.svh ====
// one row per instruction over two lines
// stimulus fields opcode, funct, rd, alu_a, alu_b, alu_funct, alu_funcs, src1, src2, imm, csr
// expected fields npc, gpr_wen, gpr_wdata, csr_wen {port 2, port 1}, csr_waddr1, csr_wdata1
task automatic load_table();
  // alu write-back from reg-reg and reg-imm ops
  rows.push_back('{OP_CALRR, ALU_ADD, 1, 'h7, 'h5, ALU_ADD, 0, 'h7, 'h5, 0, 0,
                   PC4, 1, 'hc, 2'b00, 0, 0});
  rows.push_back('{OP_CALRR, ALU_ADD, 2, 'h5, 'h7, ALU_ADD, 1, 'h5, 'h7, 0, 0,
                   PC4, 1, 'hffff_fffe, 2'b00, 0, 0});
  rows.push_back('{OP_CALRI, ALU_SLL, 3, 'h3, 'h4, ALU_SLL, 0, 'h3, 0, 'h4, 0,
                   PC4, 1, 'h30, 2'b00, 0, 0});
  rows.push_back('{OP_CALRR, ALU_SLT, 4, 'hffff_fff0, 'h2, ALU_SLT, 0, 'hffff_fff0, 'h2, 0, 0,
                   PC4, 1, 'h1, 2'b00, 0, 0});
  rows.push_back('{OP_CALRR, ALU_SLTU, 5, 'hffff_fff0, 'h2, ALU_SLTU, 0, 'hffff_fff0, 'h2, 0, 0,
                   PC4, 1, 'h0, 2'b00, 0, 0});
  rows.push_back('{OP_CALRR, ALU_XOR, 6, 'hff00_ff00, 'h0ff0_0ff0, ALU_XOR, 0, 0, 0, 0, 0,
                   PC4, 1, 'hf0f0_f0f0, 2'b00, 0, 0});
  rows.push_back('{OP_CALRR, ALU_SR, 7, 'h8000_0010, 'h4, ALU_SR, 0, 0, 0, 0, 0,
                   PC4, 1, 'h0800_0001, 2'b00, 0, 0});
  rows.push_back('{OP_CALRR, ALU_SR, 8, 'h8000_0010, 'h4, ALU_SR, 1, 0, 0, 0, 0,
                   PC4, 1, 'hf800_0001, 2'b00, 0, 0});
  rows.push_back('{OP_CALRR, ALU_OR, 9, 'h00f0_000f, 'h0f00_0f00, ALU_OR, 0, 0, 0, 0, 0,
                   PC4, 1, 'h0ff0_0f0f, 2'b00, 0, 0});
  rows.push_back('{OP_CALRR, ALU_AND, 10, 'hff00_ff00, 'h0ff0_0ff0, ALU_AND, 0, 0, 0, 0, 0,
                   PC4, 1, 'h0f00_0f00, 2'b00, 0, 0});
  rows.push_back('{OP_LUI, 0, 11, 0, 'h1234_5000, ALU_ADD, 0, 0, 0, 'h1234_5000, 0,
                   PC4, 1, 'h1234_5000, 2'b00, 0, 0});
  rows.push_back('{OP_AUIPC, 0, 12, PC, 'h2000, ALU_ADD, 0, 0, 0, 'h2000, 0,
                   PC4, 1, 'h3000, 2'b00, 0, 0});
  // each branch taken then not taken
  rows.push_back('{OP_BRANCH, BR_BEQ, 0, 'h5, 'h5, ALU_ADD, 1, 'h5, 'h5, 'h40, 0,
                   BT, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_BRANCH, BR_BEQ, 0, 'h5, 'h6, ALU_ADD, 1, 'h5, 'h6, 'h40, 0,
                   PC4, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_BRANCH, BR_BNE, 0, 'h5, 'h6, ALU_ADD, 1, 'h5, 'h6, 'h40, 0,
                   BT, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_BRANCH, BR_BNE, 0, 'h5, 'h5, ALU_ADD, 1, 'h5, 'h5, 'h40, 0,
                   PC4, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_BRANCH, BR_BLT, 0, 'hffff_ffff, 'h1, ALU_SLT, 0, 0, 0, 'h40, 0,
                   BT, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_BRANCH, BR_BLT, 0, 'h1, 'hffff_ffff, ALU_SLT, 0, 0, 0, 'h40, 0,
                   PC4, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_BRANCH, BR_BGE, 0, 'h1, 'hffff_ffff, ALU_SLT, 0, 0, 0, 'h40, 0,
                   BT, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_BRANCH, BR_BGE, 0, 'hffff_ffff, 'h1, ALU_SLT, 0, 0, 0, 'h40, 0,
                   PC4, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_BRANCH, BR_BLTU, 0, 'h1, 'hffff_ffff, ALU_SLTU, 0, 0, 0, 'h40, 0,
                   BT, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_BRANCH, BR_BLTU, 0, 'hffff_ffff, 'h1, ALU_SLTU, 0, 0, 0, 'h40, 0,
                   PC4, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_BRANCH, BR_BGEU, 0, 'hffff_ffff, 'h1, ALU_SLTU, 0, 0, 0, 'h40, 0,
                   BT, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_BRANCH, BR_BGEU, 0, 'h1, 'hffff_ffff, ALU_SLTU, 0, 0, 0, 'h40, 0,
                   PC4, 0, 0, 2'b00, 0, 0});
  // jumps with odd targets losing bit 0
  rows.push_back('{OP_JAL, 0, 1, PC, 'h4, ALU_ADD, 0, 0, 0, 'h101, 0,
                   'h1100, 1, PC4, 2'b00, 0, 0});
  rows.push_back('{OP_JALR, 0, 5, PC, 'h4, ALU_ADD, 0, 'h2001, 0, 'h10, 0,
                   'h2010, 1, PC4, 2'b00, 0, 0});
  // csrrw, ecall, mret
  rows.push_back('{OP_SYS, 1, 13, 'h8000, 0, ALU_ADD, 0, 'h8000, 0, 'h305, 'hdead_beef,
                   PC4, 1, 'hdead_beef, 2'b01, 'h305, 'h8000});
  rows.push_back('{OP_SYS, 0, 0, PC, 0, ALU_ADD, 0, 0, 0, 0, 'h800,
                   'h800, 0, 0, 2'b11, 'h341, PC});
  rows.push_back('{OP_SYS, 0, 0, 0, 0, ALU_ADD, 0, 0, 0, 'h302, 'h1234,
                   'h1234, 0, 0, 2'b00, 0, 0});
  // stores at 0x100, 0x106 and 0x10b with an alu op right behind
  rows.push_back('{OP_STORE, MEM_W, 0, 'h100, 0, ALU_ADD, 0, 'h100, 'h8765_4321, 0, 0,
                   PC4, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_STORE, MEM_H, 0, 'h100, 'h6, ALU_ADD, 0, 'h100, 'h80a5, 'h6, 0,
                   PC4, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_STORE, MEM_B, 0, 'h100, 'hb, ALU_ADD, 0, 'h100, 'hffff_ff9c, 'hb, 0,
                   PC4, 0, 0, 2'b00, 0, 0});
  rows.push_back('{OP_CALRR, ALU_ADD, 20, 'h10, 'h20, ALU_ADD, 0, 'h10, 'h20, 0, 0,
                   PC4, 1, 'h30, 2'b00, 0, 0});
  // sized and extended loads of the stored data
  rows.push_back('{OP_LOAD, MEM_W, 14, 'h100, 0, ALU_ADD, 0, 'h100, 0, 0, 0,
                   PC4, 1, 'h8765_4321, 2'b00, 0, 0});
  rows.push_back('{OP_LOAD, MEM_H, 15, 'h100, 'h6, ALU_ADD, 0, 'h100, 0, 'h6, 0,
                   PC4, 1, 'hffff_80a5, 2'b00, 0, 0});
  rows.push_back('{OP_LOAD, MEM_HU, 16, 'h100, 'h6, ALU_ADD, 0, 'h100, 0, 'h6, 0,
                   PC4, 1, 'h0000_80a5, 2'b00, 0, 0});
  rows.push_back('{OP_LOAD, MEM_B, 17, 'h100, 'hb, ALU_ADD, 0, 'h100, 0, 'hb, 0,
                   PC4, 1, 'hffff_ff9c, 2'b00, 0, 0});
  rows.push_back('{OP_LOAD, MEM_BU, 18, 'h100, 'hb, ALU_ADD, 0, 'h100, 0, 'hb, 0,
                   PC4, 1, 'h0000_009c, 2'b00, 0, 0});
  rows.push_back('{OP_LOAD, MEM_B, 19, 'h100, 'h1, ALU_ADD, 0, 'h100, 0, 'h1, 0,
                   PC4, 1, 'h0000_0043, 2'b00, 0, 0});
  rows.push_back('{OP_CALRR, ALU_ADD, 21, 'h100, 'h1, ALU_ADD, 1, 'h100, 'h1, 0, 0,
                   PC4, 1, 'hff, 2'b00, 0, 0});
endtask

// ==== dv/exec_tb.sv ====
`default_nettype none

module exec_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import exu_types_pkg::*;
  import rv_isa_pkg::*;

  localparam int    MEM_LATENCY = 3;
  localparam word_t PC  = 32'h0000_1000; // same pc for every row
  localparam word_t PC4 = PC + 32'd4;
  localparam word_t BT  = PC + 32'h40;   // taken branch target

  typedef struct packed {
    opcode_t    op;
    funct_t     fn;
    reg_idx_t   rd;
    word_t      a;
    word_t      b;
    funct_t     af;
    logic       fs;
    word_t      s1;
    word_t      s2;
    word_t      imm;
    word_t      csr;
    word_t      npc;   // expected from here on
    logic       gwe;
    word_t      gd;
    logic [1:0] cwe;   // {port 2, port 1}
    csr_idx_t   ca;
    word_t      cd;
  } row_t;

  logic     clk;
  logic     rstn;
  word_t    pc;
  opcode_t  opcode;
  funct_t   funct;
  reg_idx_t rd;
  word_t    src1;
  word_t    src2;
  word_t    imm;
  word_t    csr;
  word_t    alu_a;
  word_t    alu_b;
  funct_t   alu_funct;
  logic     alu_funcs;
  logic     id_valid;
  logic     id_ready;
  word_t    npc;
  logic     gpr_wen;
  reg_idx_t gpr_waddr;
  word_t    gpr_wdata;
  logic     csr_wen1;
  csr_idx_t csr_waddr1;
  word_t    csr_wdata1;
  logic     csr_wen2;
  csr_idx_t csr_waddr2;
  word_t    csr_wdata2;

  row_t rows[$];
  int   row_err[128];
  int   errors;
  int   checks;
  logic pend;      // memory row still waiting for its response
  int   pend_idx;

  exec_top #(
    .MEM_LATENCY (MEM_LATENCY),
    .MEM_WORDS   (256)
  ) dut_i (.*);

  always #2 clk = ~clk;

  task automatic note_error(int i);
    errors++;
    row_err[i]++;
  endtask

  task automatic compare_value(int i, string what, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %0t: row %0d %s is %h, expected %h", $time, i, what, got, exp);
      note_error(i);
    end
  endtask

  task automatic compare_enable(int i, string port, logic got, logic exp);
    checks++;
    if (exp && got !== 1'b1) begin
      $display("row %0d: the %s write enable never appeared", i, port);
      note_error(i);
    end else if (!exp && got !== 1'b0) begin
      $display("[FAIL] %0t: row %0d %s write enable high, no write expected", $time, i, port);
      note_error(i);
    end
  endtask

  // called in the cycle the pulses should be visible
  task automatic check_writes(int i);
    row_t r;
    r = rows[i];
    compare_enable(i, "gpr", gpr_wen, r.gwe);
    if (r.gwe && gpr_wen) begin
      compare_value(i, "gpr_waddr", word_t'(gpr_waddr), word_t'(r.rd));
      compare_value(i, "gpr_wdata", gpr_wdata, r.gd);
    end
    compare_enable(i, "csr port 1", csr_wen1, r.cwe[0]);
    if (r.cwe[0] && csr_wen1) begin
      compare_value(i, "csr_waddr1", word_t'(csr_waddr1), word_t'(r.ca));
      compare_value(i, "csr_wdata1", csr_wdata1, r.cd);
    end
    compare_enable(i, "csr port 2", csr_wen2, r.cwe[1]);
    if (r.cwe[1] && csr_wen2) begin
      compare_value(i, "csr_waddr2", word_t'(csr_waddr2), 32'h0000_0342); // mcause
      compare_value(i, "csr_wdata2", csr_wdata2, 32'd11);  // environment call cause
    end
    $display("row %0d op %b funct %b: %s", i, r.op, r.fn, (row_err[i] == 0) ? "ok" : "errors");
  endtask

  task automatic drive_row(row_t r);
    pc        = PC;
    opcode    = r.op;
    funct     = r.fn;
    rd        = r.rd;
    src1      = r.s1;
    src2      = r.s2;
    imm       = r.imm;
    csr       = r.csr;
    alu_a     = r.a;
    alu_b     = r.b;
    alu_funct = r.af;
    alu_funcs = r.fs;
    id_valid  = 1'b1;
  endtask

  // samples mid-cycle and checks a pending load as id_ready returns
  task automatic wait_ready();
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      if (id_ready === 1'b1) begin
        if (pend) begin
          check_writes(pend_idx);
          pend = 1'b0;
        end
        seen = 1'b1;
      end else begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 0);
    clk = 1'b0;
    rstn = 1'b1;
    drive_row('0);
    id_valid = 1'b0;
    errors = 0;
    checks = 0;
    pend = 1'b0;
    pend_idx = 0;
    load_table();
    repeat (16) @(posedge clk);
    #1;
    checks++;
    if (id_ready !== 1'b1 || gpr_wen !== 1'b0 || csr_wen1 !== 1'b0 || csr_wen2 !== 1'b0) begin
      $display("[FAIL] %0t: after reset id_ready %b, write enables %b%b%b", $time, id_ready,
               gpr_wen, csr_wen1, csr_wen2);
      errors++;
    end
    $display("reset: %s", (errors == 0) ? "ok" : "errors");
    rstn = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      drive_row(rows[i]);
      #1;
      compare_value(i, "npc", npc, rows[i].npc);
      wait_ready();
      @(posedge clk); // accept edge
      #1;
      if (rows[i].op == OP_LOAD || rows[i].op == OP_STORE) begin
        checks++;
        if (id_ready !== 1'b0) begin
          $display("[FAIL] %0t: row %0d id_ready still high after memory accept", $time, i);
          note_error(i);
        end
        pend = 1'b1;
        pend_idx = i;
      end else begin
        check_writes(i);
      end
    end
    id_valid = 1'b0;
    wait_ready();
    @(posedge clk);
    #1;
    checks++;
    if (gpr_wen !== 1'b0 || csr_wen1 !== 1'b0 || csr_wen2 !== 1'b0) begin
      $display("[FAIL] %0t: write enables still high with the stage idle", $time);
      errors++;
    end
    $display("summary: %0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // limit scales with table length and memory latency
  initial begin
    #1;
    repeat (16 + rows.size() * (MEM_LATENCY + 10)) @(posedge clk);
    $display("timeout: the rows did not complete within the cycle limit");
    $display("test failed");
    $finish;
  end

`include "exec_tb_cases.svh"

endmodule

`default_nettype wire

// ==== exec_sub.f ====
+incdir+dv
source/exu_types_pkg.sv
source/rv_isa_pkg.sv
source/alu.sv
source/next_pc.sv
source/exec_unit.sv
source/data_mem.sv
source/exec_top.sv
dv/exec_tb.sv

// ==== source/alu.sv ====
`default_nettype none

module alu (
  input  wire exu_types_pkg::word_t  alu_a,
  input  wire exu_types_pkg::word_t  alu_b,
  input  wire exu_types_pkg::funct_t funct,
  input  wire                        funcs, // sub / sra select
  output exu_types_pkg::word_t       val
);
  import exu_types_pkg::*;
  import rv_isa_pkg::*;

  logic [4:0] shamt;
  word_t      sum;
  word_t      sra_val;
  logic       lt_s;
  logic       lt_u;

  assign shamt   = alu_b[4:0];
  assign sum     = funcs ? alu_a - alu_b : alu_a + alu_b;
  assign sra_val = $signed(alu_a) >>> shamt; // keeps sign fill
  assign lt_s    = $signed(alu_a) < $signed(alu_b);
  assign lt_u    = alu_a < alu_b;

  always_comb begin
    case (funct)
      ALU_ADD:  val = sum;
      ALU_SLL:  val = alu_a << shamt;
      ALU_SLT:  val = word_t'(lt_s);
      ALU_SLTU: val = word_t'(lt_u);
      ALU_XOR:  val = alu_a ^ alu_b;
      ALU_SR:   val = funcs ? sra_val : alu_a >> shamt;
      ALU_OR:   val = alu_a | alu_b;
      ALU_AND:  val = alu_a & alu_b;
      default:  val = sum;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/data_mem.sv ====
`default_nettype none

module data_mem #(
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 3
) (
  input  wire                         clk,
  input  wire                         rstn,
  input  wire                         req_valid,
  output logic                        req_ready,
  input  wire                         req_write,
  input  wire exu_types_pkg::funct_t  req_funct,
  input  wire exu_types_pkg::word_t   req_addr,
  input  wire exu_types_pkg::word_t   req_wdata,
  output logic                        rsp_valid,
  output exu_types_pkg::word_t        rsp_rdata
);
  import exu_types_pkg::*;
  import rv_isa_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

  word_t            mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [1:0]       lane;     // byte offset in the word
  word_t            cur;
  logic [3:0]       wmask;
  word_t            wlanes;
  word_t            merged;
  logic [7:0]       rbyte;
  logic [15:0]      rhalf;
  word_t            rdata;
  word_t            rdata_q;
  logic             xfer;
  logic             pending;
  logic [CNT_W-1:0] cnt;      // cycles left until response

  assign xfer = req_valid && req_ready;
  assign idx  = req_addr[IDX_W+1:2];
  assign lane = req_addr[1:0];
  assign cur  = mem[idx];

  // store data replicated over lanes, mask picks the ones to keep
  always_comb begin
    case (req_funct)
      MEM_B: begin
        wlanes = {4{req_wdata[7:0]}};
        wmask  = 4'b0001 << lane;
      end
      MEM_H: begin
        wlanes = {2{req_wdata[15:0]}};
        wmask  = lane[1] ? 4'b1100 : 4'b0011;
      end
      MEM_W: begin
        wlanes = req_wdata;
        wmask  = 4'b1111;
      end
      default: begin
        wlanes = req_wdata;
        wmask  = 4'b0000; // unknown size, word left as is
      end
    endcase
    for (int i = 0; i < 4; i++) begin
      merged[8*i +: 8] = wmask[i] ? wlanes[8*i +: 8] : cur[8*i +: 8];
    end
  end

  assign rbyte = cur[8*lane +: 8];
  assign rhalf = lane[1] ? cur[31:16] : cur[15:0];

  always_comb begin
    case (req_funct)
      MEM_B:   rdata = {{24{rbyte[7]}}, rbyte};
      MEM_BU:  rdata = {24'b0, rbyte};
      MEM_H:   rdata = {{16{rhalf[15]}}, rhalf};
      MEM_HU:  rdata = {16'b0, rhalf};
      default: rdata = cur;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      pending <= 1'b0;
      cnt     <= '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (xfer) begin
      pending <= 1'b1;
      cnt     <= CNT_W'(MEM_LATENCY - 1);
      if (req_write) mem[idx] <= merged;
    end else if (pending) begin
      if (cnt == '0) pending <= 1'b0; // response cycle
      else cnt <= cnt - 1'b1;
    end
  end

  // read data captured with the request
  always_ff @(posedge clk) begin
    if (xfer) rdata_q <= rdata;
  end

  assign req_ready = !pending;
  assign rsp_valid = pending && (cnt == '0);
  assign rsp_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== source/exec_top.sv ====
`default_nettype none

module exec_top #(
  parameter int MEM_LATENCY = 3,
  parameter int MEM_WORDS   = 256
) (
  input  wire                           clk,
  input  wire                           rstn,
  input  wire exu_types_pkg::word_t     pc,
  input  wire exu_types_pkg::opcode_t   opcode,
  input  wire exu_types_pkg::funct_t    funct,
  input  wire exu_types_pkg::reg_idx_t  rd,
  input  wire exu_types_pkg::word_t     src1,
  input  wire exu_types_pkg::word_t     src2,
  input  wire exu_types_pkg::word_t     imm,
  input  wire exu_types_pkg::word_t     csr,
  input  wire exu_types_pkg::word_t     alu_a,
  input  wire exu_types_pkg::word_t     alu_b,
  input  wire exu_types_pkg::funct_t    alu_funct,
  input  wire                           alu_funcs,
  input  wire                           id_valid,
  output wire                           id_ready,
  output wire exu_types_pkg::word_t     npc,
  output wire                           gpr_wen,
  output wire exu_types_pkg::reg_idx_t  gpr_waddr,
  output wire exu_types_pkg::word_t     gpr_wdata,
  output wire                           csr_wen1,
  output wire exu_types_pkg::csr_idx_t  csr_waddr1,
  output wire exu_types_pkg::word_t     csr_wdata1,
  output wire                           csr_wen2,
  output wire exu_types_pkg::csr_idx_t  csr_waddr2,
  output wire exu_types_pkg::word_t     csr_wdata2
);
  import exu_types_pkg::*;

  // exec_unit <-> data_mem
  wire        req_valid;
  wire        req_ready;
  wire        req_write;
  wire funct_t req_funct;
  wire word_t req_addr;
  wire word_t req_wdata;
  wire        rsp_valid;
  wire word_t rsp_rdata;

  exec_unit u_exec_unit (.*);

  data_mem #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_data_mem (.*);

endmodule

`default_nettype wire

// ==== source/exec_unit.sv ====
`default_nettype none

module exec_unit (
  input  wire                           clk,
  input  wire                           rstn,
  // decoded fields
  input  wire exu_types_pkg::word_t     pc,
  input  wire exu_types_pkg::opcode_t   opcode,
  input  wire exu_types_pkg::funct_t    funct,
  input  wire exu_types_pkg::reg_idx_t  rd,
  input  wire exu_types_pkg::word_t     src1,
  input  wire exu_types_pkg::word_t     src2,
  input  wire exu_types_pkg::word_t     imm,
  input  wire exu_types_pkg::word_t     csr,
  input  wire exu_types_pkg::word_t     alu_a,
  input  wire exu_types_pkg::word_t     alu_b,
  input  wire exu_types_pkg::funct_t    alu_funct,
  input  wire                           alu_funcs,
  input  wire                           id_valid,
  output logic                          id_ready,
  output exu_types_pkg::word_t          npc,
  // write-back ports, one-cycle pulses
  output logic                          gpr_wen,
  output exu_types_pkg::reg_idx_t       gpr_waddr,
  output exu_types_pkg::word_t          gpr_wdata,
  output logic                          csr_wen1,
  output exu_types_pkg::csr_idx_t       csr_waddr1,
  output exu_types_pkg::word_t          csr_wdata1,
  output logic                          csr_wen2,
  output exu_types_pkg::csr_idx_t       csr_waddr2,
  output exu_types_pkg::word_t          csr_wdata2,
  // data memory request / response
  output logic                          req_valid,
  output logic                          req_write,
  output exu_types_pkg::funct_t         req_funct,
  output exu_types_pkg::word_t          req_addr,
  output exu_types_pkg::word_t          req_wdata,
  input  wire                           req_ready,
  input  wire                           rsp_valid,
  input  wire exu_types_pkg::word_t     rsp_rdata
);
  import exu_types_pkg::*;
  import rv_isa_pkg::*;

  typedef enum logic [1:0] {idle, mem_req, mem_wait} state_t;

  state_t   state;
  word_t    alu_val;
  logic     accept;
  logic     is_sys;
  logic     is_csr_op;  // csrrw and friends
  logic     is_ecall;
  logic     is_mem;
  logic     wb_wen;
  word_t    wb_data;
  csr_idx_t csr_addr;
  reg_idx_t rd_q;       // load destination

  alu u_alu (
    .alu_a (alu_a),
    .alu_b (alu_b),
    .funct (alu_funct),
    .funcs (alu_funcs),
    .val   (alu_val)
  );

  next_pc u_next_pc (
    .pc      (pc),
    .opcode  (opcode),
    .funct   (funct),
    .src1    (src1),
    .imm     (imm),
    .csr     (csr),
    .alu_val (alu_val),
    .npc     (npc)
  );

  assign accept    = id_valid && id_ready;
  assign csr_addr  = imm[11:0];
  assign is_sys    = (opcode == OP_SYS);
  assign is_csr_op = is_sys && (funct != '0);
  assign is_ecall  = is_sys && (funct == '0) && (imm == '0);
  assign is_mem    = (opcode == OP_LOAD) || (opcode == OP_STORE);

  // loads are written from the response, not here
  always_comb begin
    wb_data = alu_val;
    case (opcode)
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
      OP_CALRI, OP_CALRR: wb_wen = 1'b1;
      OP_SYS: begin
        wb_wen  = is_csr_op;
        wb_data = csr; // old csr value to rd
      end
      default:            wb_wen = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      state     <= idle;
      id_ready  <= 1'b1;
      req_valid <= 1'b0;
      gpr_wen   <= 1'b0;
      csr_wen1  <= 1'b0;
      csr_wen2  <= 1'b0;
    end else begin
      gpr_wen  <= 1'b0; // pulses drop after one cycle
      csr_wen1 <= 1'b0;
      csr_wen2 <= 1'b0;
      case (state)
        idle: if (accept) begin
          gpr_wen  <= wb_wen;
          csr_wen1 <= is_csr_op || is_ecall;
          csr_wen2 <= is_ecall;
          if (is_mem) begin
            state     <= mem_req;
            id_ready  <= 1'b0;
            req_valid <= 1'b1;
          end
        end
        mem_req: if (req_ready) begin
          req_valid <= 1'b0;
          state     <= mem_wait;
        end
        mem_wait: if (rsp_valid) begin
          gpr_wen  <= !req_write; // only loads write back
          id_ready <= 1'b1;
          state    <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      gpr_waddr  <= rd;
      gpr_wdata  <= wb_data;
      csr_waddr1 <= is_csr_op ? csr_addr : CSR_MEPC;
      csr_wdata1 <= alu_val; // pc comes through the alu for ecall
      csr_waddr2 <= CSR_MCAUSE;
      csr_wdata2 <= CAUSE_ECALL_M;
      if (is_mem) begin
        req_write <= (opcode == OP_STORE);
        req_funct <= funct;
        req_addr  <= alu_val;
        req_wdata <= src2;
        rd_q      <= rd;
      end
    end else if ((state == mem_wait) && rsp_valid) begin
      gpr_waddr <= rd_q;
      gpr_wdata <= rsp_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== source/exu_types_pkg.sv ====
`default_nettype none

package exu_types_pkg;

  // data word and byte address
  typedef logic [31:0] word_t;

  typedef logic [4:0]  reg_idx_t;  // x0..x31

  typedef logic [11:0] csr_idx_t;

  // funct3 of the instruction, also ALU op and memory size
  typedef logic [2:0]  funct_t;

  typedef logic [4:0]  opcode_t;   // inst[6:2]

endpackage

`default_nettype wire

// ==== source/next_pc.sv ====
`default_nettype none

module next_pc (
  input  wire exu_types_pkg::word_t   pc,
  input  wire exu_types_pkg::opcode_t opcode,
  input  wire exu_types_pkg::funct_t  funct,
  input  wire exu_types_pkg::word_t   src1,
  input  wire exu_types_pkg::word_t   imm,
  input  wire exu_types_pkg::word_t   csr,     // mtvec or mepc
  input  wire exu_types_pkg::word_t   alu_val, // compare result for branches
  output exu_types_pkg::word_t        npc
);
  import exu_types_pkg::*;
  import rv_isa_pkg::*;

  logic  alu_zero;
  logic  br_taken;
  logic  sys_jump;
  word_t base;
  word_t inc;
  word_t target;

  assign alu_zero = (alu_val == '0);
  // ecall and mret, no other funct-zero system op here
  assign sys_jump = (opcode == OP_SYS) && (funct == '0);

  // beq/bne see a sub result, the rest see slt/sltu
  always_comb begin
    case (funct)
      BR_BEQ:          br_taken = alu_zero;
      BR_BNE:          br_taken = !alu_zero;
      BR_BLT, BR_BLTU: br_taken = alu_val[0];
      BR_BGE, BR_BGEU: br_taken = !alu_val[0];
      default:         br_taken = 1'b0;
    endcase
  end

  always_comb begin
    base = pc;
    inc  = 32'd4;
    case (opcode)
      OP_JAL:    inc = imm;
      OP_JALR: begin
        base = src1;
        inc  = imm;
      end
      OP_BRANCH: if (br_taken) inc = imm;
      OP_SYS: if (sys_jump) begin
        base = csr; // trap vector or return address
        inc  = '0;
      end
      default: ;
    endcase
  end

  assign target = base + inc;
  assign npc    = {target[31:1], 1'b0};

endmodule

`default_nettype wire

// ==== source/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;
  import exu_types_pkg::*;

  // major opcodes, inst[6:2]
  localparam opcode_t OP_LUI    = 5'b01101;
  localparam opcode_t OP_AUIPC  = 5'b00101;
  localparam opcode_t OP_JAL    = 5'b11011;
  localparam opcode_t OP_JALR   = 5'b11001;
  localparam opcode_t OP_BRANCH = 5'b11000;
  localparam opcode_t OP_LOAD   = 5'b00000;
  localparam opcode_t OP_STORE  = 5'b01000;
  localparam opcode_t OP_CALRI  = 5'b00100; // reg-imm alu ops
  localparam opcode_t OP_CALRR  = 5'b01100; // reg-reg alu ops
  localparam opcode_t OP_SYS    = 5'b11100;

  // branch conditions
  localparam funct_t BR_BEQ  = 3'b000;
  localparam funct_t BR_BNE  = 3'b001;
  localparam funct_t BR_BLT  = 3'b100;
  localparam funct_t BR_BGE  = 3'b101;
  localparam funct_t BR_BLTU = 3'b110;
  localparam funct_t BR_BGEU = 3'b111;

  // alu ops, funcs picks sub / sra
  localparam funct_t ALU_ADD  = 3'b000;
  localparam funct_t ALU_SLL  = 3'b001;
  localparam funct_t ALU_SLT  = 3'b010;
  localparam funct_t ALU_SLTU = 3'b011;
  localparam funct_t ALU_XOR  = 3'b100;
  localparam funct_t ALU_SR   = 3'b101;
  localparam funct_t ALU_OR   = 3'b110;
  localparam funct_t ALU_AND  = 3'b111;

  // load/store size
  localparam funct_t MEM_B  = 3'b000;
  localparam funct_t MEM_H  = 3'b001;
  localparam funct_t MEM_W  = 3'b010;
  localparam funct_t MEM_BU = 3'b100;
  localparam funct_t MEM_HU = 3'b101;

  localparam csr_idx_t CSR_MEPC   = 12'h341;
  localparam csr_idx_t CSR_MCAUSE = 12'h342;

  localparam word_t CAUSE_ECALL_M = 32'd11; // env call from m-mode

endpackage

`default_nettype wire
